// ==== all.f ====
+incdir+.
core_pkg.sv
stage_if.sv
instr_decode.sv
execute_unit.sv
data_ram.sv
result_stage.sv
mips_lite_top.sv
core_props.sv
tb_checker.sv
tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -Wno-fatal -f all.f --top-module tb_top -o vsim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/vsim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== core_patterns.hex ====
// columns: tag instr a b
// tag 1 = wb (a reg, b value), 2 = beq (a taken, b target), 3 = preload lw (a reg, b addr), 0 = none, f = end
00000001 8C010000 00000001 39742468
00000003 8C020070 00000002 00000070
00000003 8C030004 00000003 00000004
00000003 8C040100 00000004 00000100
00000003 8C050174 00000005 00000174
00000001 24061234 00000006 00001234
00000001 2407FFFF 00000007 FFFFFFFF
00000001 24E80001 00000008 00000000
00000001 00854821 00000009 FFFFFFFE
00000001 24000005 00000000 00000000
00000001 00065021 0000000A 00001234
00000001 24CB0001 0000000B 00001235
00000000 00000000 00000000 00000000
00000001 01666021 0000000C 00002469
00000000 AC010200 00000000 00000000
00000001 8C0D0200 0000000D 39742468
00000002 10CA0003 00000001 00000050
00000002 10CB0003 00000000 00000000
00000002 1000FFFE 00000001 00000050
0000000F 00000000 00000000 00000000

// ==== tb_top.sv ====
`timescale 1ns/1ns
`include "core_params.svh"

module tb_top;

    logic clk = 1'b0;
    logic reset;
    logic instr_valid;
    core_pkg::word_t instr;
    logic wb_valid;
    core_pkg::reg_idx_t wb_reg;
    core_pkg::word_t wb_data;
    logic branch_taken;
    core_pkg::word_t branch_target;
    core_pkg::word_t pc;

    // four words per record
    logic [31:0] recs [0:255];
    int n_records = 0;
    core_pkg::word_t pc_exp;

    always #20 clk = ~clk;

    mips_lite_top DUT (
        .clk(clk),
        .reset(reset),
        .instr_valid(instr_valid),
        .instr(instr),
        .wb_valid(wb_valid),
        .wb_reg(wb_reg),
        .wb_data(wb_data),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .pc(pc)
    );

    tb_checker CHK (
        .clk(clk),
        .reset(reset),
        .wb_valid(wb_valid),
        .wb_reg(wb_reg),
        .wb_data(wb_data),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .pc(pc)
    );

    bind mips_lite_top core_props PROPS (
        .clk(clk),
        .reset(reset),
        .instr_valid(instr_valid),
        .instr(instr),
        .wb_valid(wb_valid),
        .branch_taken(branch_taken),
        .pc(pc)
    );

    // expected preload word for a load address
    function automatic core_pkg::word_t predict_load(input core_pkg::word_t addr);
        core_pkg::word_t idx;
        core_pkg::word_t prod;
        idx = addr >> 2;
        if (idx < `SERIES_COUNT) begin
            prod = `SERIES_STEP * (idx + `SERIES_FIRST);
            prod[31] = 1'b0;
        end else if (addr >= `FILL_BASE && addr < `FILL_BASE + 4 * `FILL_COUNT) begin
            prod = '1;
        end else begin
            prod = '0;
        end
        return prod;
    endfunction

    // run limit from the record count
    initial begin
        wait (n_records != 0);
        #((n_records + 20 + 4) * 40);
        $display("timeout: the run did not finish in time");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [31:0] tag;
        reset = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        pc_exp = '0;
        for (int i = 0; i < 256; i++) begin
            recs[i] = 'x;
        end
        $readmemh("core_patterns.hex", recs);
        // records end at tag f
        while (recs[4 * n_records] !== 32'h0000000f && n_records < 63) begin
            n_records++;
        end

        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // idle after reset
        repeat (3) begin
            @(negedge clk);
            if (pc !== '0 || wb_valid !== 1'b0 || branch_taken !== 1'b0) begin
                CHK.note_error($sformatf("Error %0t: outputs not idle after reset", $time));
            end
        end

        for (int i = 0; i < n_records; i++) begin
            tag = recs[4 * i];
            pc_exp = pc_exp + 32'd4;
            case (tag)
                32'd1: CHK.expect_wb(recs[4 * i + 2][4:0], recs[4 * i + 3]);
                32'd2: begin
                    if (recs[4 * i + 2] != '0) begin
                        CHK.expect_branch(recs[4 * i + 3]);
                        pc_exp = recs[4 * i + 3];
                    end
                end
                32'd3: CHK.expect_wb(recs[4 * i + 2][4:0], predict_load(recs[4 * i + 3]));
                default: ;
            endcase
            @(posedge clk);
            instr_valid <= 1'b1;
            instr <= recs[4 * i + 1];
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        instr <= '0;

        // wait until every expected result has been seen
        while (CHK.pending() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (pc !== pc_exp) begin
            CHK.note_error($sformatf("Error %0t: final pc %h, expected %h", $time, pc, pc_exp));
        end

        // bound assertion failures count as errors too
        CHK.error_count = CHK.error_count + DUT.PROPS.fail_count;
        CHK.print_counts();
        if (CHK.error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/1ns

module tb_checker (
    input logic clk,
    input logic reset,
    input logic wb_valid,
    input core_pkg::reg_idx_t wb_reg,
    input core_pkg::word_t wb_data,
    input logic branch_taken,
    input core_pkg::word_t branch_target,
    input core_pkg::word_t pc
);

    int error_count = 0;
    int wb_count = 0;
    int br_count = 0;

    // expected write-backs and taken branches, in order
    core_pkg::reg_idx_t wb_reg_q[$];
    core_pkg::word_t wb_data_q[$];
    core_pkg::word_t br_target_q[$];

    task automatic expect_wb(input core_pkg::reg_idx_t r, input core_pkg::word_t d);
        wb_reg_q.push_back(r);
        wb_data_q.push_back(d);
    endtask

    task automatic expect_branch(input core_pkg::word_t t);
        br_target_q.push_back(t);
    endtask

    function automatic int pending();
        return wb_reg_q.size() + br_target_q.size();
    endfunction

    task automatic note_error(input string msg);
        $display("%s", msg);
        error_count++;
    endtask

    task automatic compare_wb();
        core_pkg::reg_idx_t er;
        core_pkg::word_t ed;
        if (wb_reg_q.size() == 0) begin
            note_error($sformatf("unexpected write-back to r%0d at %0t", wb_reg, $time));
        end else begin
            er = wb_reg_q.pop_front();
            ed = wb_data_q.pop_front();
            wb_count++;
            if (wb_reg !== er || wb_data !== ed) begin
                note_error($sformatf("Error %0t: write-back r%0d=%h, expected r%0d=%h",
                                     $time, wb_reg, wb_data, er, ed));
            end
        end
    endtask

    task automatic compare_branch();
        core_pkg::word_t et;
        if (br_target_q.size() == 0) begin
            note_error($sformatf("unexpected taken branch at %0t", $time));
        end else begin
            et = br_target_q.pop_front();
            br_count++;
            if (branch_target !== et) begin
                note_error($sformatf("Error %0t: branch target %h, expected %h",
                                     $time, branch_target, et));
            end
            // pc loads the target on the same edge
            if (pc !== et) begin
                note_error($sformatf("Error %0t: pc %h after taken branch, expected %h",
                                     $time, pc, et));
            end
        end
    endtask

    // outputs settle after the rising edge
    always @(negedge clk) begin
        if (!reset) begin
            if (wb_valid) begin
                compare_wb();
            end
            if (branch_taken) begin
                compare_branch();
            end
        end
    end

    task automatic print_counts();
        $display("checked %0d write-backs, %0d branches, %0d left over, %0d errors",
                 wb_count, br_count, pending(), error_count);
    endtask

endmodule

// ==== core_props.sv ====
`timescale 1ns/1ns

module core_props (
    input logic clk,
    input logic reset,
    input logic instr_valid,
    input core_pkg::word_t instr,
    input logic wb_valid,
    input logic branch_taken,
    input core_pkg::word_t pc
);

    logic no_write;
    // failures seen by the testbench at the end
    int fail_count = 0;

    // sw and beq opcodes
    assign no_write = instr_valid && ((instr[31:26] == 6'h2b) || (instr[31:26] == 6'h04));

    // sw and beq never reach write-back
    a_no_wb: assert property (@(posedge clk) disable iff (reset)
        no_write |-> ##3 !wb_valid)
        else begin
            fail_count++;
            $error("write-back after a sw or beq");
        end

    // taken branch is a single pulse
    a_pulse: assert property (@(posedge clk) disable iff (reset)
        branch_taken |=> !branch_taken)
        else begin
            fail_count++;
            $error("branch_taken held longer than one cycle");
        end

    // pc moves only when an instruction passed execute
    a_pc: assert property (@(posedge clk) disable iff (reset)
        $changed(pc) |-> $past(instr_valid, 2))
        else begin
            fail_count++;
            $error("pc changed without a valid instruction");
        end

endmodule

// ==== mips_lite_top.sv ====
`timescale 1ns/1ns

module mips_lite_top (
    input logic clk,
    input logic reset,
    input logic instr_valid,
    input core_pkg::word_t instr,
    output logic wb_valid,
    output core_pkg::reg_idx_t wb_reg,
    output core_pkg::word_t wb_data,
    output logic branch_taken,
    output core_pkg::word_t branch_target,
    output core_pkg::word_t pc
);

    // decode -> execute
    decode_bus_if dec_bus ();
    // execute <-> result stage
    exec_bus_if ex_bus ();

    instr_decode u_decode (
        .clk(clk),
        .reset(reset),
        .instr_valid(instr_valid),
        .instr(instr),
        .dec(dec_bus.src)
    );

    execute_unit u_execute (
        .clk(clk),
        .reset(reset),
        .dec(dec_bus.dst),
        .ex(ex_bus.exec),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .pc(pc)
    );

    // register file, data memory and write-back report
    result_stage u_result (
        .clk(clk),
        .reset(reset),
        .ex(ex_bus.res),
        .wb_valid(wb_valid),
        .wb_reg(wb_reg),
        .wb_data(wb_data)
    );

endmodule

// ==== result_stage.sv ====
`timescale 1ns/1ns

module result_stage (
    input logic clk,
    input logic reset,
    exec_bus_if.res ex,
    output logic wb_valid,
    output core_pkg::reg_idx_t wb_reg,
    output core_pkg::word_t wb_data
);

    core_pkg::word_t regs [32];
    core_pkg::word_t mem_rdata;
    core_pkg::word_t wr_data;
    logic mem_write;
    logic reg_write;

    // value is the effective address for lw and sw
    data_ram u_ram (
        .clk(clk),
        .addr(ex.value),
        .write(mem_write),
        .write_data(ex.store_data),
        .read_data(mem_rdata)
    );

    assign mem_write = ex.valid && (ex.kind == core_pkg::op_sw);
    assign reg_write = ex.valid && core_pkg::writes_reg(ex.kind);
    // load data or alu sum
    assign wr_data = (ex.kind == core_pkg::op_lw) ? mem_rdata : ex.value;
    assign ex.fwd_data = wr_data;

    // read port for execute
    assign ex.rd_data_a = regs[ex.rd_idx_a];
    assign ex.rd_data_b = regs[ex.rd_idx_b];

    // r0 cleared on reset, never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write && (ex.dest != '0)) begin
            regs[ex.dest] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= reg_write;
        end
    end

    // report r0 writes as zero
    always_ff @(posedge clk) begin
        wb_reg <= ex.dest;
        wb_data <= (ex.dest == '0) ? '0 : wr_data;
    end

endmodule

// ==== data_ram.sv ====
`timescale 1ns/1ns
`include "core_params.svh"

module data_ram (
    input logic clk,
    input core_pkg::word_t addr,
    input logic write,
    input core_pkg::word_t write_data,
    output core_pkg::word_t read_data
);

    localparam int IDX_W = $clog2(`RAM_WORDS);

    // stored big-endian
    core_pkg::word_t mem [`RAM_WORDS];
    logic [IDX_W-1:0] idx;

    function automatic core_pkg::word_t swap_bytes(input core_pkg::word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // word index, addr >> 2, upper bits wrap
    assign idx = addr[IDX_W+1:2];

    // combinational read, swapped back to host order
    assign read_data = swap_bytes(mem[idx]);

    always @(posedge clk) begin
        if (write) begin
            mem[idx] <= swap_bytes(write_data);
        end
    end

    initial begin
        core_pkg::word_t prod;
        // series words, msb forced clear
        for (int k = 0; k < `SERIES_COUNT; k++) begin
            prod = `SERIES_STEP * (k + `SERIES_FIRST);
            mem[k] = swap_bytes({1'b0, prod[30:0]});
        end
        // all-ones block
        for (int k = 0; k < `FILL_COUNT; k++) begin
            mem[(`FILL_BASE >> 2) + k] = swap_bytes('1);
        end
    end

endmodule

// ==== execute_unit.sv ====
`timescale 1ns/1ns

module execute_unit (
    input logic clk,
    input logic reset,
    decode_bus_if.dst dec,
    exec_bus_if.exec ex,
    output logic branch_taken,
    output core_pkg::word_t branch_target,
    output core_pkg::word_t pc
);

    logic fwd_hit;
    logic take;
    core_pkg::word_t op_a;
    core_pkg::word_t op_b;
    core_pkg::word_t alu_b;
    core_pkg::word_t sum;
    core_pkg::word_t pc_plus4;
    core_pkg::word_t target;

    // register file read straight from the decoded sources
    assign ex.rd_idx_a = dec.rs;
    assign ex.rd_idx_b = dec.rt;

    // item in the result stage writes at the coming edge
    // r0 never forwards, it stays zero
    assign fwd_hit = ex.valid && core_pkg::writes_reg(ex.kind) && (ex.dest != '0);
    assign op_a = (fwd_hit && (ex.dest == dec.rs)) ? ex.fwd_data : ex.rd_data_a;
    assign op_b = (fwd_hit && (ex.dest == dec.rt)) ? ex.fwd_data : ex.rd_data_b;

    // addu uses rt, the rest add the immediate
    assign alu_b = (dec.kind == core_pkg::op_addu) ? op_b : dec.imm;
    assign sum = op_a + alu_b;

    // pc holds the address of the instruction in this stage
    assign pc_plus4 = pc + 32'd4;
    assign target = pc_plus4 + {dec.imm[29:0], 2'b00};
    assign take = dec.valid && (dec.kind == core_pkg::op_beq) && (op_a == op_b);

    always_ff @(posedge clk) begin
        if (reset) begin
            ex.valid <= 1'b0;
            branch_taken <= 1'b0;
            pc <= '0;
        end else begin
            ex.valid <= dec.valid;
            // single-cycle pulse
            branch_taken <= take;
            if (dec.valid) begin
                pc <= take ? target : pc_plus4;
            end
        end
    end

    always_ff @(posedge clk) begin
        ex.kind <= dec.kind;
        ex.dest <= dec.dest;
        ex.value <= sum;
        // sw data may come from the bypass too
        ex.store_data <= op_b;
        branch_target <= target;
    end

endmodule

// ==== instr_decode.sv ====
`timescale 1ns/1ns

module instr_decode (
    input logic clk,
    input logic reset,
    input logic instr_valid,
    input core_pkg::word_t instr,
    decode_bus_if.src dec
);

    // mips opcode and funct encodings
    localparam core_pkg::opcode_t OPC_SPECIAL = 6'h00;
    localparam core_pkg::opcode_t OPC_BEQ = 6'h04;
    localparam core_pkg::opcode_t OPC_ADDIU = 6'h09;
    localparam core_pkg::opcode_t OPC_LW = 6'h23;
    localparam core_pkg::opcode_t OPC_SW = 6'h2b;
    localparam logic [5:0] FUNCT_ADDU = 6'h21;

    core_pkg::opcode_t opcode;
    logic [5:0] funct;
    core_pkg::reg_idx_t rs;
    core_pkg::reg_idx_t rt;
    core_pkg::reg_idx_t rd;
    core_pkg::op_kind_t kind;

    // raw fields
    assign opcode = instr[31:26];
    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];
    assign funct = instr[5:0];

    always_comb begin
        case (opcode)
            // r-type, only addu is known
            OPC_SPECIAL: kind = (funct == FUNCT_ADDU) ? core_pkg::op_addu : core_pkg::op_nop;
            OPC_ADDIU: kind = core_pkg::op_addiu;
            OPC_LW: kind = core_pkg::op_lw;
            OPC_SW: kind = core_pkg::op_sw;
            OPC_BEQ: kind = core_pkg::op_beq;
            default: kind = core_pkg::op_nop;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= instr_valid;
        end
    end

    // payload, qualified by valid downstream
    always_ff @(posedge clk) begin
        dec.kind <= kind;
        dec.rs <= rs;
        dec.rt <= rt;
        // r-type writes rd, i-type writes rt
        dec.dest <= (kind == core_pkg::op_addu) ? rd : rt;
        dec.imm <= {{16{instr[15]}}, instr[15:0]};
    end

endmodule

// ==== stage_if.sv ====
`timescale 1ns/1ns

// decoded instruction, decode to execute
interface decode_bus_if;
    logic valid;
    core_pkg::op_kind_t kind;
    // source registers
    core_pkg::reg_idx_t rs;
    core_pkg::reg_idx_t rt;
    // rd for addu, rt for addiu and lw
    core_pkg::reg_idx_t dest;
    // immediate, already sign-extended
    core_pkg::word_t imm;

    modport src (output valid, kind, rs, rt, dest, imm);
    modport dst (input valid, kind, rs, rt, dest, imm);
endinterface

// execute to result stage, plus the register file read port back
interface exec_bus_if;
    logic valid;
    core_pkg::op_kind_t kind;
    core_pkg::reg_idx_t dest;
    // alu sum, or effective address for lw and sw
    core_pkg::word_t value;
    core_pkg::word_t store_data;

    // read port, indices from execute and data from the register file
    core_pkg::reg_idx_t rd_idx_a;
    core_pkg::reg_idx_t rd_idx_b;
    core_pkg::word_t rd_data_a;
    core_pkg::word_t rd_data_b;
    // data the result stage writes at the next edge
    core_pkg::word_t fwd_data;

    modport exec (output valid, kind, dest, value, store_data, rd_idx_a, rd_idx_b,
                  input rd_data_a, rd_data_b, fwd_data);
    modport res (input valid, kind, dest, value, store_data, rd_idx_a, rd_idx_b,
                 output rd_data_a, rd_data_b, fwd_data);
endinterface

// ==== core_pkg.sv ====
package core_pkg;

    // data or address word
    typedef logic [31:0] word_t;

    // register file index, 32 entries
    typedef logic [4:0] reg_idx_t;

    // primary opcode field, instr[31:26]
    typedef logic [5:0] opcode_t;

    // decoded operation
    // anything unknown becomes op_nop and only moves the pc
    typedef enum logic [2:0] {
        op_nop,
        op_addu,
        op_addiu,
        op_lw,
        op_sw,
        op_beq
    } op_kind_t;

    // kinds that end in a register write
    // used by the bypass and by write-back
    function automatic logic writes_reg(input op_kind_t kind);
        logic wr;
        wr = (kind == op_addu) || (kind == op_addiu) || (kind == op_lw);
        return wr;
    endfunction

endpackage

// ==== core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data memory size in 32-bit words
`define RAM_WORDS 4096

// arithmetic series preload at address 0
`define SERIES_COUNT 29
`define SERIES_STEP 32'hdcba1234
// multiplier of the first series word
`define SERIES_FIRST 2

// all-ones block, byte address of the first word
`define FILL_BASE 32'h100
`define FILL_COUNT 30

`endif
